//--- chip8_cfg.svh
// CHIP-8 core configuration
`ifndef CHIP8_CFG_SVH
`define CHIP8_CFG_SVH

// First instruction address after reset
`define CHIP8_PC_RESET 12'h200

// Return addresses held by the call stack
`define CHIP8_STACK_DEPTH 16

// Number of general purpose V registers
`define CHIP8_NUM_REGS 16

// VF carries carry, borrow and shift-out flags
`define CHIP8_FLAG_REG 15

`endif

//--- chip8_pkg.sv
// CHIP-8 shared types
`include "chip8_cfg.svh"
`default_nettype none

package chip8_pkg;

	// Register contents and immediates
	typedef logic [7:0] byte_t;

	// 4K program address space
	typedef logic [11:0] addr_t;

	// One fetched instruction word
	typedef logic [15:0] opcode_t;

	// V register select
	typedef logic [$clog2(`CHIP8_NUM_REGS)-1:0] reg_idx_t;

	// ALU functions used by 6xkk, 7xkk and the 8xy group
	typedef enum logic [2:0] {
		alu_pass,
		alu_or,
		alu_and,
		alu_xor,
		alu_add,
		alu_sub,
		alu_shr,
		alu_shl
	} alu_op_e;

	// Where the next PC comes from
	typedef enum logic [1:0] {
		pc_src_next,
		pc_src_skip,
		pc_src_jump,
		pc_src_ret
	} pc_src_e;

	// Three cycles per instruction
	typedef enum logic [1:0] {
		seq_fetch,
		seq_decode,
		seq_execute
	} seq_state_e;

endpackage

`default_nettype wire

//--- chip8_alu.sv
// CHIP-8 arithmetic and logic unit
`timescale 1ns/1ps
`default_nettype none

module chip8_alu (
	input  chip8_pkg::byte_t   a,
	input  chip8_pkg::byte_t   b,
	input  chip8_pkg::alu_op_e op,
	output chip8_pkg::byte_t   result,
	output logic               flag
);

	import chip8_pkg::*;

	// Nine bits so carry and borrow fall out of the top
	logic [8:0] sum;
	logic [8:0] diff;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = b;
		flag   = 1'b0;
		case (op)
			// Plain move of operand b
			alu_pass: result = b;
			alu_or:   result = a | b;
			alu_and:  result = a & b;
			alu_xor:  result = a ^ b;
			alu_add: begin
				result = sum[7:0];
				// Carry out
				flag   = sum[8];
			end
			alu_sub: begin
				result = diff[7:0];
				// Set when a >= b, i.e. no borrow
				flag   = ~diff[8];
			end
			alu_shr: begin
				result = {1'b0, a[7:1]};
				// LSB shifted out
				flag   = a[0];
			end
			alu_shl: begin
				result = {a[6:0], 1'b0};
				// MSB shifted out
				flag   = a[7];
			end
			default: begin
				result = b;
				flag   = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- chip8_regfile.sv
// CHIP-8 V register file
`timescale 1ns/1ps
`include "chip8_cfg.svh"
`default_nettype none

module chip8_regfile (
	input  logic                cpu_clk,
	input  logic                rst,
	input  chip8_pkg::reg_idx_t rd_idx_a,
	input  chip8_pkg::reg_idx_t rd_idx_b,
	input  logic                we_a,
	input  chip8_pkg::reg_idx_t wr_idx_a,
	input  chip8_pkg::byte_t    wr_data_a,
	input  logic                we_b,
	input  chip8_pkg::reg_idx_t wr_idx_b,
	input  chip8_pkg::byte_t    wr_data_b,
	output chip8_pkg::byte_t    rd_data_a,
	output chip8_pkg::byte_t    rd_data_b
);

	import chip8_pkg::*;

	// V0..VF
	byte_t regs [`CHIP8_NUM_REGS];

	// Asynchronous reads, no bypass from the write ports
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			for (int i = 0; i < `CHIP8_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (we_a) begin
				regs[wr_idx_a] <= wr_data_a;
			end
			// Port b last, so a flag write to VF beats the result write
			if (we_b) begin
				regs[wr_idx_b] <= wr_data_b;
			end
		end
	end

endmodule

`default_nettype wire

//--- chip8_pc_stack.sv
// CHIP-8 program counter and call stack
`timescale 1ns/1ps
`include "chip8_cfg.svh"
`default_nettype none

module chip8_pc_stack (
	input  logic               cpu_clk,
	input  logic               rst,
	input  logic               pc_en,
	input  chip8_pkg::pc_src_e pc_src,
	input  chip8_pkg::addr_t   target,
	input  logic               push,
	input  logic               pop,
	output chip8_pkg::addr_t   pc
);

	import chip8_pkg::*;

	localparam int sp_w = $clog2(`CHIP8_STACK_DEPTH);

	// Return address storage
	addr_t stack_mem [`CHIP8_STACK_DEPTH];

	// Points at the next free slot
	logic [sp_w-1:0] sp;
	logic [sp_w-1:0] sp_inc;
	logic [sp_w-1:0] sp_dec;

	addr_t pc_plus2;
	addr_t pc_plus4;
	addr_t stack_top;

	// Pointer wraps in both directions, no overflow check
	assign sp_inc = (sp == sp_w'(`CHIP8_STACK_DEPTH - 1)) ? '0 : sp + 1'b1;
	assign sp_dec = (sp == '0) ? sp_w'(`CHIP8_STACK_DEPTH - 1) : sp - 1'b1;

	assign pc_plus2  = pc + 12'd2;
	assign pc_plus4  = pc + 12'd4;
	assign stack_top = stack_mem[sp_dec];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			pc <= `CHIP8_PC_RESET;
			sp <= '0;
		end else if (pc_en) begin
			case (pc_src)
				pc_src_next: pc <= pc_plus2;
				pc_src_skip: pc <= pc_plus4;
				pc_src_jump: pc <= target;
				pc_src_ret:  pc <= stack_top;
				default:     pc <= pc_plus2;
			endcase
			if (push) begin
				sp <= sp_inc;
			end else if (pop) begin
				sp <= sp_dec;
			end
		end
	end

	// Call saves the address after the 2nnn itself
	always_ff @(posedge cpu_clk) begin
		if (pc_en && push) begin
			stack_mem[sp] <= pc_plus2;
		end
	end

endmodule

`default_nettype wire

//--- chip8_ctrl.sv
// CHIP-8 sequencer and decoder
`timescale 1ns/1ps
`include "chip8_cfg.svh"
`default_nettype none

module chip8_ctrl (
	input  logic                cpu_clk,
	input  logic                rst,
	input  chip8_pkg::opcode_t  instruction,
	input  chip8_pkg::byte_t    rd_data_a,
	input  chip8_pkg::byte_t    rd_data_b,
	input  chip8_pkg::byte_t    alu_result,
	input  logic                alu_flag,
	output logic                instr_req,
	output chip8_pkg::reg_idx_t rd_idx_a,
	output chip8_pkg::reg_idx_t rd_idx_b,
	output logic                we_a,
	output chip8_pkg::reg_idx_t wr_idx_a,
	output chip8_pkg::byte_t    wr_data_a,
	output logic                we_b,
	output chip8_pkg::reg_idx_t wr_idx_b,
	output chip8_pkg::byte_t    wr_data_b,
	output chip8_pkg::byte_t    alu_a,
	output chip8_pkg::byte_t    alu_b,
	output chip8_pkg::alu_op_e  alu_op,
	output logic                pc_en,
	output chip8_pkg::pc_src_e  pc_src,
	output chip8_pkg::addr_t    target,
	output logic                push,
	output logic                pop,
	output logic                dt_we,
	output chip8_pkg::byte_t    dt_data,
	output logic                st_we,
	output chip8_pkg::byte_t    st_data
);

	import chip8_pkg::*;

	seq_state_e state;
	opcode_t    opcode_q;

	// Opcode fields
	logic [3:0] op_hi;
	logic [3:0] op_lo;
	reg_idx_t   x_idx;
	reg_idx_t   y_idx;
	byte_t      kk;
	addr_t      nnn;
	logic       exec;

	assign op_hi = opcode_q[15:12];
	assign op_lo = opcode_q[3:0];
	assign x_idx = opcode_q[11:8];
	assign y_idx = opcode_q[7:4];
	assign kk    = opcode_q[7:0];
	assign nnn   = opcode_q[11:0];

	// Fetch, decode, execute, repeat
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			state <= seq_fetch;
		end else begin
			case (state)
				seq_fetch:   state <= seq_decode;
				seq_decode:  state <= seq_execute;
				seq_execute: state <= seq_fetch;
				default:     state <= seq_fetch;
			endcase
		end
	end

	// ROM data is valid during decode
	always_ff @(posedge cpu_clk) begin
		if (state == seq_decode) begin
			opcode_q <= instruction;
		end
	end

	assign instr_req = (state == seq_fetch);
	assign exec      = (state == seq_execute);
	// PC moves once per instruction
	assign pc_en     = exec;

	// Result to Vx, flag to VF
	assign wr_data_a = alu_result;
	assign wr_data_b = {7'b0, alu_flag};

	// Timers always load Vx
	assign dt_data = rd_data_a;
	assign st_data = rd_data_a;

	always_comb begin
		rd_idx_a = x_idx;
		rd_idx_b = y_idx;
		we_a     = 1'b0;
		wr_idx_a = x_idx;
		we_b     = 1'b0;
		wr_idx_b = reg_idx_t'(`CHIP8_FLAG_REG);
		alu_a    = rd_data_a;
		alu_b    = rd_data_b;
		alu_op   = alu_pass;
		pc_src   = pc_src_next;
		target   = nnn;
		push     = 1'b0;
		pop      = 1'b0;
		dt_we    = 1'b0;
		st_we    = 1'b0;
		if (exec) begin
			case (op_hi)
				4'h0: begin
					// 00EE return, every other 0nnn falls through
					if (nnn == 12'h0EE) begin
						pc_src = pc_src_ret;
						pop    = 1'b1;
					end
				end
				4'h1: pc_src = pc_src_jump;
				4'h2: begin
					pc_src = pc_src_jump;
					push   = 1'b1;
				end
				4'h3: if (rd_data_a == kk) pc_src = pc_src_skip;
				4'h4: if (rd_data_a != kk) pc_src = pc_src_skip;
				4'h5: begin
					if (op_lo == 4'h0 && rd_data_a == rd_data_b) begin
						pc_src = pc_src_skip;
					end
				end
				4'h6: begin
					// Vx = kk
					alu_b = kk;
					we_a  = 1'b1;
				end
				4'h7: begin
					// Vx += kk, VF untouched
					alu_b  = kk;
					alu_op = alu_add;
					we_a   = 1'b1;
				end
				4'h8: begin
					case (op_lo)
						4'h0: we_a = 1'b1;
						4'h1: begin
							alu_op = alu_or;
							we_a   = 1'b1;
						end
						4'h2: begin
							alu_op = alu_and;
							we_a   = 1'b1;
						end
						4'h3: begin
							alu_op = alu_xor;
							we_a   = 1'b1;
						end
						4'h4: begin
							alu_op = alu_add;
							we_a   = 1'b1;
							we_b   = 1'b1;
						end
						4'h5: begin
							alu_op = alu_sub;
							we_a   = 1'b1;
							we_b   = 1'b1;
						end
						4'h6: begin
							alu_op = alu_shr;
							we_a   = 1'b1;
							we_b   = 1'b1;
						end
						4'h7: begin
							// Vy - Vx, operands swapped
							alu_a  = rd_data_b;
							alu_b  = rd_data_a;
							alu_op = alu_sub;
							we_a   = 1'b1;
							we_b   = 1'b1;
						end
						4'hE: begin
							alu_op = alu_shl;
							we_a   = 1'b1;
							we_b   = 1'b1;
						end
						default: ;
					endcase
				end
				4'h9: begin
					if (op_lo == 4'h0 && rd_data_a != rd_data_b) begin
						pc_src = pc_src_skip;
					end
				end
				4'hB: begin
					// Jump to nnn + V0, wraps in 12 bits
					rd_idx_a = '0;
					target   = nnn + {4'h0, rd_data_a};
					pc_src   = pc_src_jump;
				end
				4'hF: begin
					if (kk == 8'h15) dt_we = 1'b1;
					if (kk == 8'h18) st_we = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- chip8_core.sv
// CHIP-8 instruction core
`timescale 1ns/1ps
`default_nettype none

module chip8_core (
	input  logic               cpu_clk,
	input  logic               rst,
	input  chip8_pkg::opcode_t instruction,
	output chip8_pkg::addr_t   instr_addr,
	output logic               instr_req,
	output logic               dt_we,
	output chip8_pkg::byte_t   dt_data,
	output logic               st_we,
	output chip8_pkg::byte_t   st_data
);

	import chip8_pkg::*;

	// Register file ports
	reg_idx_t rd_idx_a;
	reg_idx_t rd_idx_b;
	byte_t    rd_data_a;
	byte_t    rd_data_b;
	logic     we_a;
	reg_idx_t wr_idx_a;
	byte_t    wr_data_a;
	logic     we_b;
	reg_idx_t wr_idx_b;
	byte_t    wr_data_b;

	// ALU
	byte_t   alu_a;
	byte_t   alu_b;
	alu_op_e alu_op;
	byte_t   alu_result;
	logic    alu_flag;

	// PC and stack control
	logic    pc_en;
	pc_src_e pc_src;
	addr_t   target;
	logic    push;
	logic    pop;
	addr_t   pc;

	// ROM address follows the PC directly
	assign instr_addr = pc;

	chip8_ctrl u_ctrl (
		.cpu_clk, .rst, .instruction, .rd_data_a, .rd_data_b, .alu_result, .alu_flag,
		.instr_req, .rd_idx_a, .rd_idx_b, .we_a, .wr_idx_a, .wr_data_a,
		.we_b, .wr_idx_b, .wr_data_b, .alu_a, .alu_b, .alu_op,
		.pc_en, .pc_src, .target, .push, .pop,
		.dt_we, .dt_data, .st_we, .st_data
	);

	chip8_regfile u_regfile (
		.cpu_clk, .rst, .rd_idx_a, .rd_idx_b,
		.we_a, .wr_idx_a, .wr_data_a, .we_b, .wr_idx_b, .wr_data_b,
		.rd_data_a, .rd_data_b
	);

	chip8_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.flag   (alu_flag)
	);

	chip8_pc_stack u_pc_stack (
		.cpu_clk, .rst, .pc_en, .pc_src, .target, .push, .pop, .pc
	);

endmodule

`default_nettype wire

//--- tb_chip8.sv
// CHIP-8 core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_chip8;

	import chip8_pkg::*;

	logic    cpu_clk;
	logic    rst;
	opcode_t instruction;
	addr_t   instr_addr;
	logic    instr_req;
	logic    dt_we;
	byte_t   dt_data;
	logic    st_we;
	byte_t   st_data;

	// Program ROM with one word per even address
	opcode_t rom [2048];
	addr_t   emit_addr;
	addr_t   halt_addr;
	int      prog_len;

	// Reference interpreter state
	byte_t   m_v [16];
	addr_t   m_stack [16];
	logic [3:0] m_sp;
	addr_t   m_pc;
	logic    exp_dt_we;
	logic    exp_st_we;
	byte_t   exp_dt;
	byte_t   exp_st;

	// Fetch tracking and bookkeeping
	logic    req_seen;
	addr_t   req_addr;
	logic    in_exec;
	int      fetch_gap;
	int      fetches;
	int      halt_hits;
	int      checks;
	int      errors;
	int      cycles;
	int      cycle_limit;

	chip8_core u_dut (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.instruction (instruction),
		.instr_addr  (instr_addr),
		.instr_req   (instr_req),
		.dt_we       (dt_we),
		.dt_data     (dt_data),
		.st_we       (st_we),
		.st_data     (st_data)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #50 cpu_clk = ~cpu_clk;
	end

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	function automatic byte_t rand_byte();
		return 8'($urandom());
	endfunction

	task automatic emit(input opcode_t op);
		rom[emit_addr[11:1]] = op;
		emit_addr = emit_addr + 12'd2;
		prog_len++;
	endtask

	task automatic build_program();
		logic [3:0] x;
		logic [3:0] y;
		byte_t      k;
		logic [3:0] alu_fns [9] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
		// Unused words decode as the dropped Annn opcode
		for (int i = 0; i < 2048; i++) begin
			rom[i] = {4'hA, 11'(i), 1'b0};
		end
		emit_addr = 12'h200;
		// Loads and adds followed by Vx to the delay timer
		for (int r = 0; r < 16; r++) begin
			emit({4'h6, 4'(r), rand_byte()});
			emit({4'h7, 4'(r), rand_byte()});
			emit({4'hF, 4'(r), 8'h15});
		end
		// Each 8xy function runs once with a random x and once with x = F
		for (int i = 0; i < 9; i++) begin
			for (int p = 0; p < 2; p++) begin
				x = (p == 0) ? 4'($urandom_range(14, 0)) : 4'hF;
				y = 4'($urandom_range(15, 0));
				emit({4'h6, x, rand_byte()});
				emit({4'h6, y, rand_byte()});
				emit({4'h8, x, y, alu_fns[i]});
				emit({4'hF, x, 8'h15});
				emit(16'hFF18);
			end
		end
		// Odd c gives unequal operands
		for (int c = 0; c < 8; c++) begin
			k = rand_byte();
			emit({8'h61, k});
			emit({8'h62, c[0] ? ~k : k});
			case (c[2:1])
				2'd0: emit({8'h31, c[0] ? ~k : k});
				2'd1: emit({8'h41, c[0] ? ~k : k});
				2'd2: emit(16'h5120);
				default: emit(16'h9120);
			endcase
			emit({8'h63, 8'(c)});
			emit(16'h7301);
		end
		// Plain jump over one filler
		emit({4'h1, emit_addr + 12'd4});
		emit(16'h6EEE);
		// Bnnn lands V0 bytes past nnn
		emit(16'h6004);
		emit({4'hB, emit_addr + 12'd2});
		emit(16'h6EEE);
		emit(16'h6EEE);
		// Nested call followed by a read back of what the subroutines wrote
		emit(16'h2600);
		emit(16'hF115);
		emit(16'hF218);
		// Dropped opcodes
		emit(16'hA123);
		emit(16'hE19E);
		emit(16'hF107);
		emit(16'h00E0);
		emit(16'h8128);
		emit(16'hF115);
		halt_addr = emit_addr;
		emit({4'h1, emit_addr});
		emit_addr = 12'h600;
		emit(16'h6133);
		emit(16'h2640);
		emit(16'h7101);
		emit(16'h00EE);
		emit_addr = 12'h640;
		emit(16'h6244);
		emit(16'h00EE);
	endtask

	// Executes one opcode by the CHIP-8 rules
	task automatic model_step(input opcode_t op);
		reg_idx_t   x;
		reg_idx_t   y;
		byte_t      kk;
		addr_t      nnn;
		addr_t      next_pc;
		logic [8:0] wide;
		byte_t      res;
		logic       flag;
		logic       has_res;
		logic       has_flag;
		x = op[11:8];
		y = op[7:4];
		kk = op[7:0];
		nnn = op[11:0];
		next_pc = m_pc + 12'd2;
		exp_dt_we = 1'b0;
		exp_st_we = 1'b0;
		res = '0;
		flag = 1'b0;
		has_res = 1'b1;
		has_flag = 1'b0;
		case (op[15:12])
			4'h0: begin
				if (nnn == 12'h0EE) begin
					m_sp = m_sp - 4'd1;
					next_pc = m_stack[m_sp];
				end
			end
			4'h1: next_pc = nnn;
			4'h2: begin
				m_stack[m_sp] = m_pc + 12'd2;
				m_sp = m_sp + 4'd1;
				next_pc = nnn;
			end
			4'h3: if (m_v[x] == kk) next_pc = m_pc + 12'd4;
			4'h4: if (m_v[x] != kk) next_pc = m_pc + 12'd4;
			4'h5: if (op[3:0] == 4'h0 && m_v[x] == m_v[y]) next_pc = m_pc + 12'd4;
			4'h6: m_v[x] = kk;
			4'h7: m_v[x] = m_v[x] + kk;
			4'h8: begin
				case (op[3:0])
					4'h0: res = m_v[y];
					4'h1: res = m_v[x] | m_v[y];
					4'h2: res = m_v[x] & m_v[y];
					4'h3: res = m_v[x] ^ m_v[y];
					4'h4: begin
						wide = {1'b0, m_v[x]} + {1'b0, m_v[y]};
						res = wide[7:0];
						flag = wide[8];
						has_flag = 1'b1;
					end
					4'h5: begin
						res = m_v[x] - m_v[y];
						flag = (m_v[x] >= m_v[y]);
						has_flag = 1'b1;
					end
					4'h6: begin
						res = m_v[x] >> 1;
						flag = m_v[x][0];
						has_flag = 1'b1;
					end
					4'h7: begin
						res = m_v[y] - m_v[x];
						flag = (m_v[y] >= m_v[x]);
						has_flag = 1'b1;
					end
					4'hE: begin
						res = m_v[x] << 1;
						flag = m_v[x][7];
						has_flag = 1'b1;
					end
					default: has_res = 1'b0;
				endcase
				if (has_res) m_v[x] = res;
				// VF gets the flag even when x is F
				if (has_flag) m_v[15] = {7'b0, flag};
			end
			4'h9: if (op[3:0] == 4'h0 && m_v[x] != m_v[y]) next_pc = m_pc + 12'd4;
			4'hB: next_pc = nnn + {4'h0, m_v[0]};
			4'hF: begin
				exp_dt_we = (kk == 8'h15);
				exp_st_we = (kk == 8'h18);
				exp_dt = m_v[x];
				exp_st = m_v[x];
			end
			default: ;
		endcase
		m_pc = next_pc;
	endtask

	// ROM model and checker on the falling edge where outputs are stable
	always @(negedge cpu_clk) begin
		opcode_t op;
		fetch_gap++;
		check_value("dt_we", {15'b0, in_exec & exp_dt_we}, {15'b0, dt_we});
		check_value("st_we", {15'b0, in_exec & exp_st_we}, {15'b0, st_we});
		if (in_exec && exp_dt_we) check_value("dt_data", {8'h0, exp_dt}, {8'h0, dt_data});
		if (in_exec && exp_st_we) check_value("st_data", {8'h0, exp_st}, {8'h0, st_data});
		in_exec = 1'b0;
		// Strobe just dropped, so this is the decode cycle
		if (req_seen && !instr_req) begin
			op = rom[req_addr[11:1]];
			instruction = op;
			check_value("instr_addr", {4'h0, m_pc}, {4'h0, req_addr});
			if (fetches > 0) begin
				check_value("instr_req period", 16'd3, 16'(fetch_gap));
			end else begin
				check_value("sp", 16'h0, {12'h0, u_dut.u_pc_stack.sp});
			end
			// Register file must match the model before each instruction
			for (int i = 0; i < 16; i++) begin
				check_value($sformatf("V%0X", i), {8'h0, m_v[i]},
					{8'h0, u_dut.u_regfile.regs[i]});
			end
			if (m_pc == halt_addr) halt_hits++;
			model_step(op);
			fetches++;
			fetch_gap = 0;
			in_exec = 1'b1;
		end
		req_seen = instr_req;
		if (instr_req) req_addr = instr_addr;
	end

	// One request per instruction
	assert property (@(posedge cpu_clk) disable iff (rst) instr_req |=> !instr_req)
	else begin
		errors++;
		$display("instr_req was high in two consecutive cycles");
	end

	// Timer strobes come only in execute just before the next fetch
	assert property (@(posedge cpu_clk) disable iff (rst) (dt_we || st_we) |=> instr_req)
	else begin
		errors++;
		$display("A timer strobe was not followed by a fetch");
	end

	always @(posedge cpu_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			errors++;
			$display("Timeout after %0d cycles before the program reached its final loop",
				cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		instruction = '0;
		m_sp = '0;
		m_pc = 12'h200;
		exp_dt_we = 1'b0;
		exp_st_we = 1'b0;
		exp_dt = '0;
		exp_st = '0;
		req_seen = 1'b0;
		req_addr = '0;
		in_exec = 1'b0;
		fetch_gap = 0;
		fetches = 0;
		halt_hits = 0;
		checks = 0;
		errors = 0;
		cycles = 0;
		prog_len = 0;
		for (int i = 0; i < 16; i++) begin
			m_v[i] = '0;
			m_stack[i] = '0;
		end
		void'($urandom(64179));
		build_program();
		// Three cycles per instruction doubled plus the reset cycles
		cycle_limit = prog_len * 3 * 2 + 8;
		repeat (8) @(negedge cpu_clk);
		rst = 1'b0;
		// Self jump seen twice means the program is done
		while (halt_hits < 2) @(posedge cpu_clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
chip8_pkg.sv
chip8_alu.sv
chip8_regfile.sv
chip8_pc_stack.sv
chip8_ctrl.sv
chip8_core.sv
tb_chip8.sv

//--- Makefile
# Verilator simulation of the CHIP-8 core

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_chip8
FILELIST := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
